// File: logic/icache_pkg.sv
package icache_pkg;

    // Cache geometry
    localparam int TAG_W          = 20;
    localparam int INDEX_W        = 7;
    localparam int NUM_SETS       = 1 << INDEX_W;
    localparam int OFFSET_W       = 5;
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 8;
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE;
    localparam int NUM_WAYS       = 2;

    // Word count returned with each line
    localparam int RNUM_W = 4;

    localparam int ADDR_W = TAG_W + INDEX_W + OFFSET_W;

    typedef logic [LINE_W-1:0] line_t;

    // CPU request address as split by the cache
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } cpu_addr_t;

    // Line write after a miss, shared by data, tag and LRU storage
    typedef struct packed {
        logic               strobe;
        logic               way;
        logic [INDEX_W-1:0] index;
        logic [TAG_W-1:0]   tag;
        line_t              line;
    } refill_wr_t;

    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_replace,
        st_refill
    } cache_state_t;

endpackage

// File: logic/line_store.sv
`timescale 1ns/1ps

module line_store
    import icache_pkg::*;
(
    input  logic                       clk,
    input  logic                       lookup_en,
    input  logic [INDEX_W-1:0]         lookup_index,
    input  refill_wr_t                 refill,
    output line_t [NUM_WAYS-1:0]       way_lines
);

    // One full-line array per way, read and written a whole line at a time
    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        line_t lines [NUM_SETS];
        line_t rd_line;
        logic  wr_en;

        assign wr_en = refill.strobe && (refill.way == 1'(w));

        always_ff @(posedge clk) begin
            if (wr_en) begin
                lines[refill.index] <= refill.line;
            end
        end

        // Synchronous read, data valid the cycle after the strobe
        always_ff @(posedge clk) begin
            if (lookup_en) begin
                rd_line <= lines[lookup_index];
            end
        end

        assign way_lines[w] = rd_line;
    end

endmodule

// File: logic/tag_lookup.sv
`timescale 1ns/1ps

module tag_lookup
    import icache_pkg::*;
(
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [INDEX_W-1:0]    lookup_index,
    input  logic [TAG_W-1:0]      lookup_tag,
    input  refill_wr_t            refill,
    output logic [NUM_WAYS-1:0]   way_hit,
    output logic                  hit
);

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        logic [NUM_SETS-1:0] valid_bits;
        logic [TAG_W-1:0]    tags [NUM_SETS];
        logic                wr_en;
        logic                entry_valid;
        logic [TAG_W-1:0]    entry_tag;

        assign wr_en = refill.strobe && (refill.way == 1'(w));

        // Valid bit set once a line lands
        always_ff @(posedge clk) begin
            if (!resetn) begin
                valid_bits <= '0;
            end else if (wr_en) begin
                valid_bits[refill.index] <= 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (wr_en) begin
                tags[refill.index] <= refill.tag;
            end
        end

        // Asynchronous read at the buffered index
        assign entry_valid = valid_bits[lookup_index];
        assign entry_tag   = tags[lookup_index];

        assign way_hit[w] = entry_valid && (entry_tag == lookup_tag);
    end

    assign hit = |way_hit;

endmodule

// File: logic/lru_policy.sv
`timescale 1ns/1ps

module lru_policy
    import icache_pkg::*;
(
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  lookup_active,
    input  logic [INDEX_W-1:0]    lookup_index,
    input  logic [NUM_WAYS-1:0]   way_hit,
    input  refill_wr_t            refill,
    output logic                  victim_way
);

    // One bit per set naming the way to evict next
    logic [NUM_SETS-1:0] lru_bits;
    logic                lookup_hit;

    assign lookup_hit = lookup_active && (|way_hit);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            lru_bits <= '0;
        end else if (lookup_hit) begin
            // Point at the way that was not used
            lru_bits[lookup_index] <= way_hit[0];
        end else if (refill.strobe) begin
            lru_bits[refill.index] <= ~refill.way;
        end
    end

    assign victim_way = lru_bits[lookup_index];

endmodule

// File: logic/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl
    import icache_pkg::*;
(
    input  logic                  clk,
    input  logic                  resetn,

    // CPU side
    input  logic                  valid,
    input  cpu_addr_t             req,
    output logic                  addr_ok,
    output logic                  data_ok,
    output line_t                 rdata,
    output logic [RNUM_W-1:0]     rnum,

    // Lookup results
    input  logic                  hit,
    input  line_t [NUM_WAYS-1:0]  way_lines,
    input  logic [NUM_WAYS-1:0]   way_hit,
    input  logic                  victim_way,

    // Memory side
    output logic                  rd_req,
    output logic [ADDR_W-1:0]     rd_addr,
    input  logic                  rd_rdy,
    input  logic                  ret_valid,
    input  line_t                 ret_data,

    // Storage control
    output logic                  lookup_en,
    output logic [INDEX_W-1:0]    lookup_index,
    output logic [TAG_W-1:0]      rb_tag,
    output logic                  lookup_active,
    output refill_wr_t            refill
);

    cache_state_t state;
    cache_state_t next_state;

    cpu_addr_t rb;
    logic      accept;
    logic      rp_way;
    line_t     hit_line;

    assign addr_ok = valid && ((state == st_idle) || (state == st_lookup && hit));
    assign accept  = valid && addr_ok;

    // Request buffer
    always_ff @(posedge clk) begin
        if (accept) begin
            rb <= req;
        end
    end

    // Victim is fixed once the miss is known
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rp_way <= 1'b0;
        end else if (state == st_lookup && !hit) begin
            rp_way <= victim_way;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (accept) begin
                    next_state = st_lookup;
                end
            end
            st_lookup: begin
                if (!hit) begin
                    next_state = st_replace;
                end else if (!accept) begin
                    next_state = st_idle;
                end
            end
            st_replace: begin
                if (rd_rdy) begin
                    next_state = st_refill;
                end
            end
            st_refill: begin
                if (ret_valid) begin
                    next_state = st_idle;
                end
            end
            default: next_state = st_idle;
        endcase
    end

    // Data array is read with the new index while the tag compare uses the buffer
    assign lookup_en     = accept;
    assign lookup_index  = accept ? req.index : rb.index;
    assign lookup_active = (state == st_lookup);
    assign rb_tag        = rb.tag;

    // Line miss request
    assign rd_req  = (state == st_replace);
    assign rd_addr = {rb.tag, rb.index, {OFFSET_W{1'b0}}};

    // Refill always targets the buffered request
    assign refill.strobe = (state == st_refill) && ret_valid;
    assign refill.way    = rp_way;
    assign refill.index  = rb.index;
    assign refill.tag    = rb.tag;
    assign refill.line   = ret_data;

    always_comb begin
        hit_line = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (way_hit[w]) begin
                hit_line = hit_line | way_lines[w];
            end
        end
    end

    assign data_ok = (state == st_lookup && hit) || (state == st_refill && ret_valid);
    assign rdata   = (state == st_refill) ? ret_data : hit_line;

    // Words left from the addressed word to the end of the line
    assign rnum = RNUM_W'(WORDS_PER_LINE)
                - RNUM_W'(rb.offset[OFFSET_W-1:$clog2(WORD_W/8)]);

endmodule

// File: logic/icache_top.sv
`timescale 1ns/1ps

module icache_top
    import icache_pkg::*;
(
    input  logic                 clk,
    input  logic                 resetn,

    // CPU port
    input  logic                 valid,
    input  cpu_addr_t            req,
    output logic                 addr_ok,
    output logic                 data_ok,
    output line_t                rdata,
    output logic [RNUM_W-1:0]    rnum,

    // Line read port
    output logic                 rd_req,
    output logic [ADDR_W-1:0]    rd_addr,
    input  logic                 rd_rdy,
    input  logic                 ret_valid,
    input  line_t                ret_data
);

    logic                  lookup_en;
    logic [INDEX_W-1:0]    lookup_index;
    logic [TAG_W-1:0]      rb_tag;
    logic                  lookup_active;
    refill_wr_t            refill;
    line_t [NUM_WAYS-1:0]  way_lines;
    logic [NUM_WAYS-1:0]   way_hit;
    logic                  hit;
    logic                  victim_way;

    cache_ctrl u_ctrl (
        .clk           (clk),
        .resetn        (resetn),
        .valid         (valid),
        .req           (req),
        .addr_ok       (addr_ok),
        .data_ok       (data_ok),
        .rdata         (rdata),
        .rnum          (rnum),
        .hit           (hit),
        .way_lines     (way_lines),
        .way_hit       (way_hit),
        .victim_way    (victim_way),
        .rd_req        (rd_req),
        .rd_addr       (rd_addr),
        .rd_rdy        (rd_rdy),
        .ret_valid     (ret_valid),
        .ret_data      (ret_data),
        .lookup_en     (lookup_en),
        .lookup_index  (lookup_index),
        .rb_tag        (rb_tag),
        .lookup_active (lookup_active),
        .refill        (refill)
    );

    line_store u_lines (
        .clk          (clk),
        .lookup_en    (lookup_en),
        .lookup_index (lookup_index),
        .refill       (refill),
        .way_lines    (way_lines)
    );

    // Tag compare and LRU work on the buffered index, carried in the refill bundle
    tag_lookup u_tags (
        .clk          (clk),
        .resetn       (resetn),
        .lookup_index (refill.index),
        .lookup_tag   (rb_tag),
        .refill       (refill),
        .way_hit      (way_hit),
        .hit          (hit)
    );

    lru_policy u_lru (
        .clk           (clk),
        .resetn        (resetn),
        .lookup_active (lookup_active),
        .lookup_index  (refill.index),
        .way_hit       (way_hit),
        .refill        (refill),
        .victim_way    (victim_way)
    );

endmodule

// File: verification/refill_memory.sv
`timescale 1ns/1ps

module refill_memory
    import icache_pkg::*;
(
    input  logic              clk,
    input  logic              resetn,
    input  logic              rd_req,
    input  logic [ADDR_W-1:0] rd_addr,
    output logic              rd_rdy,
    output logic              ret_valid,
    output line_t             ret_data
);

    // Word i of a line holds the line address plus 4*i
    function automatic line_t line_contents(input logic [ADDR_W-1:0] line_addr);
        line_t line;
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            line[i*WORD_W +: WORD_W] = line_addr + ADDR_W'(4 * i);
        end
        return line;
    endfunction

    initial begin
        int unsigned       wait_cycles;
        logic [ADDR_W-1:0] held_addr;
        void'($urandom(32'hce36_36c7));
        rd_rdy    <= 1'b0;
        ret_valid <= 1'b0;
        ret_data  <= '0;
        forever begin
            @(posedge clk);
            if (resetn && rd_req) begin
                // Hold the request off for 0 to 3 cycles
                wait_cycles = $urandom_range(3, 0);
                repeat (wait_cycles) @(posedge clk);
                rd_rdy <= 1'b1;
                @(posedge clk);
                // Handshake edge, address is taken here
                held_addr = rd_addr;
                rd_rdy    <= 1'b0;
                wait_cycles = $urandom_range(4, 1);
                repeat (wait_cycles) @(posedge clk);
                ret_valid <= 1'b1;
                ret_data  <= line_contents(held_addr);
                @(posedge clk);
                ret_valid <= 1'b0;
            end
        end
    end

endmodule

// File: verification/tb_icache.sv
`timescale 1ns/1ps

module tb_icache
    import icache_pkg::*;
();

    localparam int WAIT_LIMIT = 64;

    logic              clk;
    logic              resetn;
    logic              valid;
    cpu_addr_t         req;
    logic              addr_ok;
    logic              data_ok;
    line_t             rdata;
    logic [RNUM_W-1:0] rnum;
    logic              rd_req;
    logic [ADDR_W-1:0] rd_addr;
    logic              rd_rdy;
    logic              ret_valid;
    line_t             ret_data;
    logic              refill_pending;

    icache_top uut (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .req       (req),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rnum      (rnum),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data)
    );

    refill_memory refill_mem (
        .clk       (clk),
        .resetn    (resetn),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    function automatic cpu_addr_t build_addr(input logic [TAG_W-1:0] tag,
                                             input logic [INDEX_W-1:0] index,
                                             input logic [2:0] word);
        cpu_addr_t a;
        a.tag    = tag;
        a.index  = index;
        a.offset = {word, 2'b00};
        return a;
    endfunction

    // Byte address with the offset within the line cleared
    function automatic logic [ADDR_W-1:0] line_address(input cpu_addr_t a);
        return ADDR_W'(a) & ~ADDR_W'(WORDS_PER_LINE * (WORD_W / 8) - 1);
    endfunction

    function automatic line_t expected_line(input cpu_addr_t a);
        line_t line;
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            line[i*WORD_W +: WORD_W] = line_address(a) + ADDR_W'(4 * i);
        end
        return line;
    endfunction

    // Words from the addressed one to the end of the line
    function automatic logic [RNUM_W-1:0] expected_rnum(input cpu_addr_t a);
        return RNUM_W'(WORDS_PER_LINE - int'(a.offset >> 2));
    endfunction

    task automatic check_quiet();
        assert (!rd_req && !data_ok)
            else abort_run($sformatf("ERROR at %0t: rd_req or data_ok high while idle", $time));
    endtask

    task automatic check_response(input cpu_addr_t a);
        assert (rdata == expected_line(a))
            else abort_run($sformatf("ERROR at %0t: rdata %h for line %h",
                                     $time, rdata, line_address(a)));
        assert (rnum == expected_rnum(a))
            else abort_run($sformatf("ERROR at %0t: rnum %0d, expected %0d",
                                     $time, rnum, expected_rnum(a)));
    endtask

    // One request and its response
    task automatic access_line(input cpu_addr_t a, input bit expect_hit);
        int waited;
        bit saw_miss;
        saw_miss = 1'b0;
        waited   = 0;
        valid <= 1'b1;
        req   <= a;
        do begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) abort_run("timed out waiting for addr_ok");
        end while (!addr_ok);
        valid  <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (rd_req) begin
                saw_miss = 1'b1;
                assert (rd_addr == line_address(a))
                    else abort_run($sformatf("ERROR at %0t: rd_addr %h, expected %h",
                                             $time, rd_addr, line_address(a)));
            end
            if (waited > WAIT_LIMIT) abort_run("timed out waiting for data_ok");
        end while (!data_ok);
        check_response(a);
        if (expect_hit) begin
            assert (waited == 1 && !saw_miss)
                else abort_run($sformatf("ERROR at %0t: expected hit, latency %0d miss %b",
                                         $time, waited, saw_miss));
        end else begin
            assert (saw_miss)
                else abort_run($sformatf("ERROR at %0t: expected miss for line %h",
                                         $time, line_address(a)));
        end
    endtask

    // Resident hits with valid held
    task automatic stream_hits(input cpu_addr_t addrs[$]);
        int sent;
        int answered;
        int waited;
        bit streaming;
        sent      = 0;
        answered  = 0;
        waited    = 0;
        streaming = 1'b0;
        valid <= 1'b1;
        req   <= addrs[0];
        while (answered < addrs.size()) begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) abort_run("timed out during back-to-back hits");
            assert (!rd_req)
                else abort_run($sformatf("ERROR at %0t: rd_req during resident hits", $time));
            if (streaming) begin
                assert (data_ok)
                    else abort_run($sformatf("ERROR at %0t: gap in data_ok stream", $time));
            end
            if (data_ok) begin
                streaming = 1'b1;
                check_response(addrs[answered]);
                if (sent < addrs.size()) begin
                    assert (addr_ok)
                        else abort_run($sformatf("ERROR at %0t: addr_ok low with data_ok",
                                                 $time));
                end
                answered++;
            end
            if (addr_ok) begin
                sent++;
                if (sent < addrs.size()) begin
                    req <= addrs[sent];
                end else begin
                    valid <= 1'b0;
                end
            end
        end
    endtask

    hold_miss_request: assert property (
        @(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr)
    ) else abort_run($sformatf("ERROR at %0t: miss request changed before rd_rdy", $time));

    no_data_while_requesting: assert property (
        @(posedge clk) disable iff (!resetn)
        rd_req |-> !data_ok
    ) else abort_run($sformatf("ERROR at %0t: data_ok while rd_req is high", $time));

    // Between the miss handshake and the returned beat
    always @(posedge clk) begin
        if (!resetn) begin
            refill_pending <= 1'b0;
        end else begin
            if (refill_pending) begin
                assert (data_ok == ret_valid)
                    else abort_run($sformatf("ERROR at %0t: data_ok %b with ret_valid %b",
                                             $time, data_ok, ret_valid));
            end
            if (rd_req && rd_rdy) begin
                refill_pending <= 1'b1;
            end else if (ret_valid) begin
                refill_pending <= 1'b0;
            end
        end
    end

    initial begin
        cpu_addr_t stream_q[$];
        valid  <= 1'b0;
        req    <= '0;
        resetn <= 1'b0;
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            if (i > 0) check_quiet();
        end
        resetn <= 1'b1;
        repeat (3) begin
            @(posedge clk);
            check_quiet();
        end

        // Cold miss and a hit in the same line
        access_line(build_addr(20'h12345, 7'd5, 3'd3), 1'b0);
        access_line(build_addr(20'h12345, 7'd5, 3'd6), 1'b1);

        access_line(build_addr(20'h00abc, 7'd20, 3'd0), 1'b0);
        access_line(build_addr(20'h7f001, 7'd21, 3'd7), 1'b0);
        stream_q.push_back(build_addr(20'h12345, 7'd5, 3'd1));
        stream_q.push_back(build_addr(20'h00abc, 7'd20, 3'd5));
        stream_q.push_back(build_addr(20'h7f001, 7'd21, 3'd7));
        stream_q.push_back(build_addr(20'h12345, 7'd5, 3'd0));
        stream_hits(stream_q);

        // A and B share set 60 and C evicts B
        access_line(build_addr(20'h00111, 7'd60, 3'd2), 1'b0);
        access_line(build_addr(20'h00222, 7'd60, 3'd4), 1'b0);
        access_line(build_addr(20'h00111, 7'd60, 3'd5), 1'b1);
        access_line(build_addr(20'h00333, 7'd60, 3'd0), 1'b0);
        access_line(build_addr(20'h00111, 7'd60, 3'd7), 1'b1);
        access_line(build_addr(20'h00222, 7'd60, 3'd1), 1'b0);

        // Misses under random rd_rdy and return delays
        for (int k = 0; k < 6; k++) begin
            access_line(build_addr(20'h40000 + 20'(k), 7'(90 + k), 3'(k)), 1'b0);
        end

        $display("all tests passed");
        $finish;
    end

endmodule

// File: build.f
logic/icache_pkg.sv
logic/line_store.sv
logic/tag_lookup.sv
logic/lru_policy.sv
logic/cache_ctrl.sv
logic/icache_top.sv
verification/refill_memory.sv
verification/tb_icache.sv
